// File: source/cpuPkg.sv
// Shared widths, opcodes, control encodings and the instruction word layout.
// Every unit of the core refers to these by scoped names.
package cpuPkg;
    localparam int wordWidth     = 16;
    localparam int pcWidth       = 9;
    localparam int dataAddrWidth = 8;
    localparam int regIdxWidth   = 4;
    localparam int flagWidth     = 4;

    // flag vector is {O, Z, S, C}
    localparam int flagOvf   = 3;
    localparam int flagZero  = 2;
    localparam int flagSign  = 1;
    localparam int flagCarry = 0;

    localparam logic [3:0] opAdd      = 4'b0000;
    localparam logic [3:0] opSub      = 4'b0001;
    localparam logic [3:0] opNand     = 4'b0010;
    localparam logic [3:0] opShiftGrp = 4'b0011;
    localparam logic [3:0] opNor      = 4'b0100;
    localparam logic [3:0] opLw       = 4'b1000;
    localparam logic [3:0] opSw       = 4'b1001;
    localparam logic [3:0] opJmp      = 4'b1100;
    localparam logic [3:0] opBeq      = 4'b1101;
    localparam logic [3:0] opLdInd    = 4'b1111;

    // low two bits of s2 inside the shift group
    localparam logic [1:0] subNeg = 2'b00;
    localparam logic [1:0] subSar = 2'b01;
    localparam logic [1:0] subShr = 2'b10;
    localparam logic [1:0] subShl = 2'b11;

    localparam logic [2:0] aluAdd  = 3'd0;
    localparam logic [2:0] aluSub  = 3'd1;
    localparam logic [2:0] aluNand = 3'd2;
    localparam logic [2:0] aluNor  = 3'd3;
    localparam logic [2:0] aluNeg  = 3'd4;
    localparam logic [2:0] aluSar  = 3'd5;
    localparam logic [2:0] aluShr  = 3'd6;
    localparam logic [2:0] aluShl  = 3'd7;

    localparam logic [1:0] regS1    = 2'd0; // operand A
    localparam logic [1:0] shiftImm = 2'd1;
    localparam logic [1:0] regS2    = 2'd0; // operand B
    localparam logic [1:0] regD     = 2'd1;

    localparam logic [1:0] addrLoad     = 2'd0;
    localparam logic [1:0] addrStore    = 2'd1;
    localparam logic [1:0] addrIndirect = 2'd2;

    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] d;
        logic [3:0] s1;
        logic [3:0] s2;
    } regFmt;

    // address view, load form or store/jump form
    typedef union packed {
        struct packed {
            logic [3:0] opcode;
            logic [3:0] spare;
            logic [7:0] loadAddr;
        } ld;
        struct packed {
            logic [3:0] opcode;
            logic [7:0] target; // sw address or jmp target
            logic [3:0] spare;
        } st;
    } addrFmt;

    typedef union packed {
        regFmt  r;
        addrFmt a;
    } instrWord;
endpackage

// File: source/decodeBus.sv
// Decoded control bundle from the decoder to execute, fetch and the output side.
`timescale 1ns/10ps
interface decodeBus;
    logic [2:0] aluOp;
    logic [1:0] selA;
    logic [1:0] selB;
    logic       regWrite;
    logic       wbFromMem;
    logic       memWrite;
    logic [1:0] addrSel;
    logic       jump;
    logic       branch;
    logic       updateFlags;

    modport driver (
        output aluOp, selA, selB, regWrite, wbFromMem, memWrite,
               addrSel, jump, branch, updateFlags
    );

    modport exec (
        input aluOp, selA, selB, jump, branch
    );

    modport out (
        input memWrite, addrSel, regWrite, wbFromMem, updateFlags
    );
endinterface

// File: source/fetchUnit.sv
// Program counter and instruction memory with the program load port.
// The PC advances only on edges where run is high.
`timescale 1ns/10ps
module fetchUnit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        run,
    input  logic                        progWrite,
    input  logic [cpuPkg::pcWidth-1:0]  progAddr,
    input  cpuPkg::instrWord            progData,
    decodeBus.exec                      ctrl,
    input  logic                        zero,
    input  logic [cpuPkg::pcWidth-1:0]  branchTarget,
    output logic [cpuPkg::pcWidth-1:0]  pc,
    output cpuPkg::instrWord            instr
);
    cpuPkg::instrWord imem [0:(1 << cpuPkg::pcWidth) - 1];
    logic [cpuPkg::pcWidth-1:0] pcNext;

    assign instr = imem[pc]; // async read

    always_comb begin
        if (ctrl.jump) begin
            pcNext = cpuPkg::pcWidth'(instr.a.st.target); // zero extended
        end else if (ctrl.branch && zero) begin
            pcNext = branchTarget;
        end else begin
            pcNext = pc + 1'b1; // wraps at 512
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc <= '0;
        end else if (run) begin
            pc <= pcNext;
        end
    end

    always_ff @(posedge clk) begin
        if (progWrite) begin
            imem[progAddr] <= progData;
        end
    end

    // the environment must finish loading before run goes high
    loadWhileIdle: assert property (@(posedge clk) disable iff (!rst) !(progWrite && run))
        else $error("program write while core is running");
endmodule

// File: source/instrDecoder.sv
// Opcode decode to datapath controls, purely combinational.
// Unused opcodes fall through to the defaults and behave as no-ops.
`timescale 1ns/10ps
module instrDecoder (
    input  cpuPkg::instrWord instr,
    decodeBus.driver         ctrl
);
    always_comb begin
        ctrl.aluOp       = cpuPkg::aluAdd;
        ctrl.selA        = cpuPkg::regS1;
        ctrl.selB        = cpuPkg::regS2;
        ctrl.regWrite    = 1'b0;
        ctrl.wbFromMem   = 1'b0;
        ctrl.memWrite    = 1'b0;
        ctrl.addrSel     = cpuPkg::addrLoad;
        ctrl.jump        = 1'b0;
        ctrl.branch      = 1'b0;
        ctrl.updateFlags = 1'b0;
        case (instr.r.opcode)
            cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opNand, cpuPkg::opNor: begin
                ctrl.regWrite    = 1'b1;
                ctrl.updateFlags = 1'b1;
                case (instr.r.opcode)
                    cpuPkg::opSub:  ctrl.aluOp = cpuPkg::aluSub;
                    cpuPkg::opNand: ctrl.aluOp = cpuPkg::aluNand;
                    cpuPkg::opNor:  ctrl.aluOp = cpuPkg::aluNor;
                    default:        ctrl.aluOp = cpuPkg::aluAdd;
                endcase
            end
            cpuPkg::opShiftGrp: begin
                ctrl.regWrite    = 1'b1;
                ctrl.updateFlags = 1'b1;
                case (instr.r.s2[1:0])
                    cpuPkg::subSar: ctrl.aluOp = cpuPkg::aluSar;
                    cpuPkg::subShr: ctrl.aluOp = cpuPkg::aluShr;
                    cpuPkg::subShl: ctrl.aluOp = cpuPkg::aluShl;
                    default:        ctrl.aluOp = cpuPkg::aluNeg; // neg works on s1
                endcase
                if (instr.r.s2[1:0] != cpuPkg::subNeg) begin
                    ctrl.selA = cpuPkg::shiftImm; // amount from the s1 field
                    ctrl.selB = cpuPkg::regD;
                end
            end
            cpuPkg::opLw: begin
                ctrl.regWrite  = 1'b1;
                ctrl.wbFromMem = 1'b1;
            end
            cpuPkg::opLdInd: begin
                ctrl.regWrite  = 1'b1;
                ctrl.wbFromMem = 1'b1;
                ctrl.addrSel   = cpuPkg::addrIndirect;
            end
            cpuPkg::opSw: begin
                ctrl.memWrite = 1'b1;
                ctrl.addrSel  = cpuPkg::addrStore;
            end
            cpuPkg::opJmp: ctrl.jump = 1'b1;
            cpuPkg::opBeq: begin
                ctrl.aluOp       = cpuPkg::aluSub; // s1 - s2 sets zero
                ctrl.branch      = 1'b1;
                ctrl.updateFlags = 1'b1;
            end
            default: ;
        endcase
    end

    writeStoreExclusive: assert final (!(ctrl.regWrite && ctrl.memWrite))
        else $error("register write and memory write decoded together");
endmodule

// File: source/registerFile.sv
// Sixteen general registers, three async read ports and one clocked write port.
`timescale 1ns/10ps
module registerFile (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            writeEn,
    input  logic [cpuPkg::regIdxWidth-1:0]  writeIdx,
    input  logic [cpuPkg::wordWidth-1:0]    writeData,
    input  logic [cpuPkg::regIdxWidth-1:0]  idxD,
    input  logic [cpuPkg::regIdxWidth-1:0]  idxS1,
    input  logic [cpuPkg::regIdxWidth-1:0]  idxS2,
    output logic [cpuPkg::wordWidth-1:0]    valD,
    output logic [cpuPkg::wordWidth-1:0]    valS1,
    output logic [cpuPkg::wordWidth-1:0]    valS2
);
    logic [cpuPkg::wordWidth-1:0] regs [0:(1 << cpuPkg::regIdxWidth) - 1];

    assign valD  = regs[idxD];
    assign valS1 = regs[idxS1];
    assign valS2 = regs[idxS2];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < (1 << cpuPkg::regIdxWidth); i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeIdx] <= writeData; // already gated by run
        end
    end
endmodule

// File: source/aluCore.sv
// Operand selection, the eight ALU operations and next-flag computation.
// Shifts take their amount from the s1 field and shift the rd value.
`timescale 1ns/10ps
module aluCore (
    decodeBus.exec                        ctrl,
    input  cpuPkg::instrWord              instr,
    input  logic [cpuPkg::wordWidth-1:0]  valS1,
    input  logic [cpuPkg::wordWidth-1:0]  valS2,
    input  logic [cpuPkg::wordWidth-1:0]  valD,
    output logic [cpuPkg::wordWidth-1:0]  result,
    output logic [cpuPkg::flagWidth-1:0]  flagsNext
);
    logic [cpuPkg::wordWidth-1:0] opA;
    logic [cpuPkg::wordWidth-1:0] opB;
    logic [cpuPkg::wordWidth-1:0] negB;
    logic [3:0] amt;
    logic [3:0] shlIdx;
    logic       carry;
    logic       ovf;

    assign opA = (ctrl.selA == cpuPkg::shiftImm) ? cpuPkg::wordWidth'(instr.r.s1) : valS1;
    assign opB = (ctrl.selB == cpuPkg::regD) ? valD : valS2;
    assign negB   = -opB;
    assign amt    = opA[3:0];
    assign shlIdx = 4'd0 - amt; // 16 - n, taken mod 16

    always_comb begin
        result = '0;
        carry  = 1'b0;
        ovf    = 1'b0;
        case (ctrl.aluOp)
            cpuPkg::aluAdd: begin
                {carry, result} = {1'b0, opA} + {1'b0, opB};
                ovf = (opA[15] == opB[15]) && (result[15] != opA[15]);
            end
            cpuPkg::aluSub: begin
                {carry, result} = {1'b0, opA} + {1'b0, negB}; // A plus -B
                ovf = (opA[15] == negB[15]) && (result[15] != opA[15]);
            end
            cpuPkg::aluNand: result = ~(opA & opB);
            cpuPkg::aluNor:  result = ~(opA | opB);
            cpuPkg::aluNeg: begin
                result = -opA;
                ovf = (result != '0) && (result[15] == opA[15]);
            end
            cpuPkg::aluSar: begin
                result = $signed(opB) >>> amt; // sign fill
                carry  = (amt != 4'd0) && opB[amt - 4'd1];
            end
            cpuPkg::aluShr: begin
                result = opB >> amt;
                carry  = (amt != 4'd0) && opB[amt - 4'd1];
                ovf    = opB[15]; // sign of the original operand
            end
            default: begin // shl
                result = opB << amt;
                carry  = (amt != 4'd0) && opB[shlIdx];
                ovf    = (amt == 4'd1) && (opB[15] ^ opB[14]);
            end
        endcase
    end

    always_comb begin
        flagsNext                    = '0;
        flagsNext[cpuPkg::flagOvf]   = ovf;
        flagsNext[cpuPkg::flagZero]  = (result == '0);
        flagsNext[cpuPkg::flagSign]  = result[15];
        flagsNext[cpuPkg::flagCarry] = carry;
    end
endmodule

// File: source/dataMemory.sv
// Data address selection and the 256-word data memory.
// Reads are async; stores commit on the clock edge while run is high.
`timescale 1ns/10ps
module dataMemory (
    input  logic                              clk,
    input  logic                              run,
    decodeBus.out                             ctrl,
    input  cpuPkg::instrWord                  instr,
    input  logic [cpuPkg::wordWidth-1:0]      indirectBase,
    input  logic [cpuPkg::wordWidth-1:0]      storeData,
    output logic [cpuPkg::dataAddrWidth-1:0]  memAddr,
    output logic [cpuPkg::wordWidth-1:0]      loadData
);
    logic [cpuPkg::wordWidth-1:0] mem [0:(1 << cpuPkg::dataAddrWidth) - 1];

    always_comb begin
        case (ctrl.addrSel)
            cpuPkg::addrStore:    memAddr = instr.a.st.target;
            cpuPkg::addrIndirect: memAddr = indirectBase[cpuPkg::dataAddrWidth-1:0]; // s1 value
            default:              memAddr = instr.a.ld.loadAddr;
        endcase
    end

    assign loadData = mem[memAddr];

    always_ff @(posedge clk) begin
        if (ctrl.memWrite && run) begin
            mem[memAddr] <= storeData;
        end
    end
endmodule

// File: source/writebackUnit.sv
// Register write-data select, flag register and the one-cycle retirement trace.
// The trace shows what each instruction committed, flags as they stand after it.
`timescale 1ns/10ps
module writebackUnit (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              run,
    decodeBus.out                             ctrl,
    input  logic [cpuPkg::pcWidth-1:0]        pc,
    input  logic [cpuPkg::regIdxWidth-1:0]    destIdx,
    input  logic [cpuPkg::wordWidth-1:0]      aluResult,
    input  logic [cpuPkg::wordWidth-1:0]      loadData,
    input  logic [cpuPkg::dataAddrWidth-1:0]  memAddr,
    input  logic [cpuPkg::wordWidth-1:0]      storeData,
    input  logic [cpuPkg::flagWidth-1:0]      flagsNext,
    output logic                              regWriteEn,
    output logic [cpuPkg::wordWidth-1:0]      regWriteData,
    output logic                              retireValid,
    output logic [cpuPkg::pcWidth-1:0]        retirePc,
    output logic                              retireRegWrite,
    output logic [cpuPkg::regIdxWidth-1:0]    retireRegIdx,
    output logic [cpuPkg::wordWidth-1:0]      retireRegData,
    output logic                              retireMemWrite,
    output logic [cpuPkg::dataAddrWidth-1:0]  retireMemAddr,
    output logic [cpuPkg::wordWidth-1:0]      retireMemData,
    output logic [cpuPkg::flagWidth-1:0]      retireFlags
);
    logic [cpuPkg::flagWidth-1:0] flags;
    logic [cpuPkg::flagWidth-1:0] flagsAfter;

    assign regWriteEn   = ctrl.regWrite && run;
    assign regWriteData = ctrl.wbFromMem ? loadData : aluResult;
    assign flagsAfter   = ctrl.updateFlags ? flagsNext : flags;

    always_ff @(posedge clk) begin
        if (!rst) begin
            flags <= '0;
        end else if (ctrl.updateFlags && run) begin
            flags <= flagsNext;
        end
    end

    // unused fields of a record read as zero
    always_ff @(posedge clk) begin
        if (!rst) begin
            retireValid    <= 1'b0;
            retirePc       <= '0;
            retireRegWrite <= 1'b0;
            retireRegIdx   <= '0;
            retireRegData  <= '0;
            retireMemWrite <= 1'b0;
            retireMemAddr  <= '0;
            retireMemData  <= '0;
            retireFlags    <= '0;
        end else begin
            retireValid <= run;
            if (run) begin
                retirePc       <= pc;
                retireRegWrite <= ctrl.regWrite;
                retireRegIdx   <= ctrl.regWrite ? destIdx : '0;
                retireRegData  <= ctrl.regWrite ? regWriteData : '0;
                retireMemWrite <= ctrl.memWrite;
                retireMemAddr  <= ctrl.memWrite ? memAddr : '0;
                retireMemData  <= ctrl.memWrite ? storeData : '0;
                retireFlags    <= flagsAfter;
            end
        end
    end
endmodule

// File: source/processorCore.sv
// Top level of the single-cycle core, wiring all units to plain ports.
// Load the program with run low, then hold run high to execute.
`timescale 1ns/10ps
module processorCore (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              run,
    input  logic                              progWrite,
    input  logic [cpuPkg::pcWidth-1:0]        progAddr,
    input  logic [cpuPkg::wordWidth-1:0]      progData,
    output logic                              retireValid,
    output logic [cpuPkg::pcWidth-1:0]        retirePc,
    output logic                              retireRegWrite,
    output logic [cpuPkg::regIdxWidth-1:0]    retireRegIdx,
    output logic [cpuPkg::wordWidth-1:0]      retireRegData,
    output logic                              retireMemWrite,
    output logic [cpuPkg::dataAddrWidth-1:0]  retireMemAddr,
    output logic [cpuPkg::wordWidth-1:0]      retireMemData,
    output logic [cpuPkg::flagWidth-1:0]      retireFlags
);
    decodeBus ctrl ();

    cpuPkg::instrWord                   instr;
    logic [cpuPkg::pcWidth-1:0]         pc;
    logic [cpuPkg::wordWidth-1:0]       valD;
    logic [cpuPkg::wordWidth-1:0]       valS1;
    logic [cpuPkg::wordWidth-1:0]       valS2;
    logic [cpuPkg::wordWidth-1:0]       aluResult;
    logic [cpuPkg::flagWidth-1:0]       flagsNext;
    logic [cpuPkg::dataAddrWidth-1:0]   memAddr;
    logic [cpuPkg::wordWidth-1:0]       loadData;
    logic                               regWriteEn;
    logic [cpuPkg::wordWidth-1:0]       regWriteData;

    fetchUnit fetchUnit_inst (
        .clk(clk), .rst(rst), .run(run),
        .progWrite(progWrite), .progAddr(progAddr), .progData(progData),
        .ctrl(ctrl.exec),
        .zero(flagsNext[cpuPkg::flagZero]), // beq compare result
        .branchTarget(valD[cpuPkg::pcWidth-1:0]),
        .pc(pc), .instr(instr)
    );

    instrDecoder instrDecoder_inst (.instr(instr), .ctrl(ctrl.driver));

    registerFile registerFile_inst (
        .clk(clk), .rst(rst),
        .writeEn(regWriteEn), .writeIdx(instr.r.d), .writeData(regWriteData),
        .idxD(instr.r.d), .idxS1(instr.r.s1), .idxS2(instr.r.s2),
        .valD(valD), .valS1(valS1), .valS2(valS2)
    );

    aluCore aluCore_inst (
        .ctrl(ctrl.exec), .instr(instr),
        .valS1(valS1), .valS2(valS2), .valD(valD),
        .result(aluResult), .flagsNext(flagsNext)
    );

    dataMemory dataMemory_inst (
        .clk(clk), .run(run), .ctrl(ctrl.out), .instr(instr),
        .indirectBase(valS1), .storeData(valS2),
        .memAddr(memAddr), .loadData(loadData)
    );

    writebackUnit writebackUnit_inst (
        .clk(clk), .rst(rst), .run(run), .ctrl(ctrl.out),
        .pc(pc), .destIdx(instr.r.d), .aluResult(aluResult), .loadData(loadData),
        .memAddr(memAddr), .storeData(valS2), .flagsNext(flagsNext),
        .regWriteEn(regWriteEn), .regWriteData(regWriteData),
        .retireValid(retireValid), .retirePc(retirePc),
        .retireRegWrite(retireRegWrite), .retireRegIdx(retireRegIdx),
        .retireRegData(retireRegData), .retireMemWrite(retireMemWrite),
        .retireMemAddr(retireMemAddr), .retireMemData(retireMemData),
        .retireFlags(retireFlags)
    );
endmodule

// File: test/tbProcessorCore.sv
// Self-checking testbench for the single-cycle core.
// Loads the program from the golden file, runs it and compares every retirement record.
`timescale 1ns/10ps
module tbProcessorCore;
    localparam int retireTimeout = 20; // cycles allowed per record
    localparam int pauseAfter    = 16; // run drops after this record
    localparam int holdCycles    = 5;

    logic        clk = 1'b0;
    logic        rst;
    logic        run;
    logic        progWrite;
    logic [8:0]  progAddr;
    logic [15:0] progData;
    logic        retireValid;
    logic [8:0]  retirePc;
    logic        retireRegWrite;
    logic [3:0]  retireRegIdx;
    logic [15:0] retireRegData;
    logic        retireMemWrite;
    logic [7:0]  retireMemAddr;
    logic [15:0] retireMemData;
    logic [3:0]  retireFlags;

    logic [8:0]  progAddrQ [$];
    logic [15:0] progWordQ [$];
    logic [8:0]  expPc [$];
    logic        expRegWrite [$];
    logic [3:0]  expRegIdx [$];
    logic [15:0] expRegData [$];
    logic        expMemWrite [$];
    logic [7:0]  expMemAddr [$];
    logic [15:0] expMemData [$];
    logic [3:0]  expFlags [$];

    processorCore processorCore_inst (
        .clk(clk), .rst(rst), .run(run),
        .progWrite(progWrite), .progAddr(progAddr), .progData(progData),
        .retireValid(retireValid), .retirePc(retirePc),
        .retireRegWrite(retireRegWrite), .retireRegIdx(retireRegIdx),
        .retireRegData(retireRegData), .retireMemWrite(retireMemWrite),
        .retireMemAddr(retireMemAddr), .retireMemData(retireMemData),
        .retireFlags(retireFlags)
    );

    always #2 clk = ~clk; // 4 ns period

    task automatic stopOnError(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run aborted at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            stopOnError($sformatf("Fail %s: actual 0x%0h, expected 0x%0h",
                                  name, actual, expected));
        end
    endtask

    task automatic readGolden();
        int fd;
        int code;
        logic [8*8-1:0]   tag;
        logic [8*120-1:0] rest;
        logic [15:0]      f [0:7];
        fd = $fopen("test/processorCore_golden.txt", "r");
        if (fd == 0) begin
            stopOnError("could not open the golden file test/processorCore_golden.txt");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                break; // trailing whitespace at end of file
            end
            if (tag == "#") begin
                code = $fgets(rest, fd); // skip comment text
            end else if (tag == "P") begin
                code = $fscanf(fd, "%h %h", f[0], f[1]);
                if (code != 2) begin
                    stopOnError("a program line in the golden file is malformed");
                end
                progAddrQ.push_back(f[0][8:0]);
                progWordQ.push_back(f[1]);
            end else if (tag == "R") begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                               f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                if (code != 8) begin
                    stopOnError("a retirement line in the golden file is malformed");
                end
                expPc.push_back(f[0][8:0]);
                expRegWrite.push_back(f[1][0]);
                expRegIdx.push_back(f[2][3:0]);
                expRegData.push_back(f[3]);
                expMemWrite.push_back(f[4][0]);
                expMemAddr.push_back(f[5][7:0]);
                expMemData.push_back(f[6]);
                expFlags.push_back(f[7][3:0]);
            end else begin
                stopOnError("the golden file holds a line of unknown kind");
            end
        end
        $fclose(fd);
        if (progAddrQ.size() == 0 || expPc.size() == 0) begin
            stopOnError("the golden file holds no program or no expected records");
        end
    endtask

    // trace must read as reset while the core is idle
    task automatic checkIdleTrace();
        checkValue("retireValid", retireValid, 0);
        checkValue("retirePc", retirePc, 0);
        checkValue("retireRegWrite", retireRegWrite, 0);
        checkValue("retireRegIdx", retireRegIdx, 0);
        checkValue("retireRegData", retireRegData, 0);
        checkValue("retireMemWrite", retireMemWrite, 0);
        checkValue("retireMemAddr", retireMemAddr, 0);
        checkValue("retireMemData", retireMemData, 0);
        checkValue("retireFlags", retireFlags, 0);
    endtask

    task automatic loadProgram();
        for (int i = 0; i < progAddrQ.size(); i++) begin
            @(posedge clk);
            progWrite <= 1'b1;
            progAddr  <= progAddrQ[i];
            progData  <= progWordQ[i];
        end
        @(posedge clk);
        progWrite <= 1'b0;
    endtask

    task automatic waitRetire();
        int cycles;
        cycles = 0;
        @(negedge clk); // outputs settled mid-cycle
        while (!retireValid) begin
            cycles++;
            if (cycles >= retireTimeout) begin
                stopOnError("timed out waiting for the next retirement record");
            end
            @(negedge clk);
        end
    endtask

    task automatic compareRecord(input int i);
        checkValue("retirePc", retirePc, expPc[i]);
        checkValue("retireRegWrite", retireRegWrite, expRegWrite[i]);
        checkValue("retireRegIdx", retireRegIdx, expRegIdx[i]);
        checkValue("retireRegData", retireRegData, expRegData[i]);
        checkValue("retireMemWrite", retireMemWrite, expMemWrite[i]);
        checkValue("retireMemAddr", retireMemAddr, expMemAddr[i]);
        checkValue("retireMemData", retireMemData, expMemData[i]);
        checkValue("retireFlags", retireFlags, expFlags[i]);
    endtask

    // no record may appear while run is low
    task automatic holdRun();
        repeat (holdCycles) begin
            @(negedge clk);
            checkValue("retireValid", retireValid, 0);
        end
        @(posedge clk);
        run <= 1'b1;
    endtask

    initial begin
        rst       = 1'b0;
        run       = 1'b0;
        progWrite = 1'b0;
        progAddr  = '0;
        progData  = '0;
        readGolden();
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        checkIdleTrace();
        loadProgram();
        @(negedge clk);
        checkIdleTrace();
        @(posedge clk);
        run <= 1'b1;
        for (int i = 0; i < expPc.size(); i++) begin
            waitRetire();
            compareRecord(i);
            if (i == pauseAfter) begin
                @(posedge clk);
                run <= 1'b0; // next record is already committing on this edge
            end else if (i == pauseAfter + 1) begin
                holdRun();
            end
        end
        $display("SIMULATION PASSED");
        $finish;
    end
endmodule

// File: flist.f
source/cpuPkg.sv
source/decodeBus.sv
source/fetchUnit.sv
source/instrDecoder.sv
source/registerFile.sv
source/aluCore.sv
source/dataMemory.sv
source/writebackUnit.sv
source/processorCore.sv
test/tbProcessorCore.sv

// File: test/processorCore_golden.txt
# P address word  (program, hex)
# R pc regWrite regIdx regData memWrite memAddr memData flags  (hex, flags O Z S C)
P 000 2100
P 001 0211
P 002 3310
P 003 4400
P 004 3412
P 005 0543
P 006 1653
P 007 3541
P 008 3213
P 009 3413
P 00A 3623
P 00B 3601
P 00C 3582
P 00D 33F3
P 00E 3730
P 00F 2851
P 010 93C8
P 011 893C
P 012 9F87
P 013 FA50
P 014 5123
P 015 C200
P 020 DC13
P 021 D511
P 0F8 0B9A
P 0F9 1C37
P 0FA CFA0
R 000 1 1 FFFF 0 00 0000 2
R 001 1 2 FFFE 0 00 0000 3
R 002 1 3 0001 0 00 0000 0
R 003 1 4 FFFF 0 00 0000 2
R 004 1 4 7FFF 0 00 0000 9
R 005 1 5 8000 0 00 0000 A
R 006 1 6 7FFF 0 00 0000 9
R 007 1 5 F800 0 00 0000 2
R 008 1 2 FFFC 0 00 0000 3
R 009 1 4 FFFE 0 00 0000 A
R 00A 1 6 FFFC 0 00 0000 3
R 00B 1 6 FFFC 0 00 0000 2
R 00C 1 5 00F8 0 00 0000 8
R 00D 1 3 8000 0 00 0000 2
R 00E 1 7 8000 0 00 0000 A
R 00F 1 8 FF07 0 00 0000 2
R 010 0 0 0000 1 3C FF07 2
R 011 1 9 FF07 0 00 0000 2
R 012 0 0 0000 1 F8 8000 2
R 013 1 A 8000 0 00 0000 2
R 014 0 0 0000 0 00 0000 2
R 015 0 0 0000 0 00 0000 2
R 020 0 0 0000 0 00 0000 9
R 021 0 0 0000 0 00 0000 5
R 0F8 1 B 7F07 0 00 0000 9
R 0F9 1 C 0000 0 00 0000 D
R 0FA 0 0 0000 0 00 0000 D
